//--- Bender.yml
package:
  name: ray_state

sources:
  - logic/rt_pkg.sv
  - logic/dp_ram.sv
  - logic/ray_event_decode.sv
  - logic/bounce_state_exec.sv
  - logic/scache_out_fifo.sv
  - logic/ray_state_top.sv
  - target: simulation
    files:
      - testbench/ray_state_chk.sv
      - testbench/ray_state_monitor.sv
      - testbench/tb_ray_state.sv

//--- logic/bounce_state_exec.sv
`timescale 1ns/100ps
`default_nettype none

module bounce_state_exec (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        dec_valid,
  input  logic [rt_pkg::ray_id_w-1:0] dec_ray_id,
  input  rt_pkg::ray_event_e          dec_kind,
  output logic                        exec_stall,
  input  logic                        tri_wren,
  input  logic [rt_pkg::ray_id_w-1:0] tri_waddr,
  input  logic [rt_pkg::tri_id_w-1:0] tri_wdata,
  input  logic [rt_pkg::bounce_w-1:0] max_reflect,
  output logic                        res_valid,
  output logic [rt_pkg::ray_id_w-1:0] res_ray_id,
  output logic [rt_pkg::tri_id_w-1:0] res_tri_id,
  output logic                        res_is_shadow,
  output logic                        res_is_miss,
  output logic                        res_is_last,
  input  logic                        res_full
);

  rt_pkg::exec_state_e state;
  logic [rt_pkg::ray_id_w-1:0] clr_addr;
  logic clearing;
  logic advance;

  // Read stage, RAM outputs line up with these registers
  logic rd_valid;
  logic [rt_pkg::ray_id_w-1:0] rd_ray;
  rt_pkg::ray_event_e rd_kind;
  logic [rt_pkg::tri_id_w-1:0] tri_rdata;
  logic [rt_pkg::bounce_w-1:0] state_rdata;
  logic [rt_pkg::bounce_w-1:0] rd_cnt;

  // Write stage
  logic wr_valid;
  logic [rt_pkg::ray_id_w-1:0] wr_ray;
  rt_pkg::ray_event_e wr_kind;
  logic [rt_pkg::tri_id_w-1:0] wr_tri;
  logic [rt_pkg::bounce_w-1:0] wr_cnt;
  logic [rt_pkg::bounce_w-1:0] wr_new_cnt;
  logic wr_shadow;
  logic wr_last;

  // Entry written on the edge the read stage last loaded
  logic lw_valid;
  logic [rt_pkg::ray_id_w-1:0] lw_ray;
  logic [rt_pkg::bounce_w-1:0] lw_cnt;

  logic st_wren;
  logic [rt_pkg::ray_id_w-1:0] st_waddr;
  logic [rt_pkg::bounce_w-1:0] st_wdata;

  assign clearing   = (state == rt_pkg::st_clear);
  assign advance    = !clearing && !res_full;
  assign exec_stall = !advance;

  // Zero every bounce counter once after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rt_pkg::st_clear;
      clr_addr <= '0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == rt_pkg::last_ray_id) begin
        state <= rt_pkg::st_run;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      wr_valid <= 1'b0;
      lw_valid <= 1'b0;
    end else if (advance) begin
      rd_valid <= dec_valid;
      wr_valid <= rd_valid;
      lw_valid <= wr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      rd_ray  <= dec_ray_id;
      rd_kind <= dec_kind;
      wr_ray  <= rd_ray;
      wr_kind <= rd_kind;
      wr_tri  <= tri_rdata;
      wr_cnt  <= rd_cnt;
      lw_ray  <= wr_ray;
      lw_cnt  <= wr_new_cnt;
    end
  end

  // Newest update wins: write stage first, then the entry just written
  always_comb begin
    if (wr_valid && wr_ray == rd_ray) begin
      rd_cnt = wr_new_cnt;
    end else if (lw_valid && lw_ray == rd_ray) begin
      rd_cnt = lw_cnt;
    end else begin
      rd_cnt = state_rdata;
    end
  end

  assign wr_shadow  = (wr_kind == rt_pkg::ev_shadow_lit) ||
                      (wr_kind == rt_pkg::ev_shadow_blocked);
  assign wr_last    = (wr_kind == rt_pkg::ev_miss) || (wr_shadow && wr_cnt == max_reflect);
  assign wr_new_cnt = wr_last ? '0 : wr_cnt + 1'b1;

  assign st_wren  = clearing || (wr_valid && advance);
  assign st_waddr = clearing ? clr_addr : wr_ray;
  assign st_wdata = clearing ? '0 : wr_new_cnt;

  dp_ram #(
    .width(rt_pkg::tri_id_w)
  ) i_tri_ram (
    .clk  (clk),
    .wren (tri_wren),
    .waddr(tri_waddr),
    .wdata(tri_wdata),
    .rden (advance),
    .raddr(dec_ray_id),
    .rdata(tri_rdata)
  );

  dp_ram #(
    .width(rt_pkg::bounce_w)
  ) i_state_ram (
    .clk  (clk),
    .wren (st_wren),
    .waddr(st_waddr),
    .wdata(st_wdata),
    .rden (advance),
    .raddr(dec_ray_id),
    .rdata(state_rdata)
  );

  assign res_valid     = wr_valid && advance;
  assign res_ray_id    = wr_ray;
  assign res_tri_id    = wr_tri;
  assign res_is_shadow = wr_shadow;
  assign res_is_miss   = (wr_kind == rt_pkg::ev_miss) || (wr_kind == rt_pkg::ev_shadow_lit);
  assign res_is_last   = wr_last;

endmodule

`default_nettype wire

//--- logic/dp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dp_ram #(
  parameter int width = 4
) (
  input  logic                       clk,
  input  logic                       wren,
  input  logic [rt_pkg::ray_id_w-1:0] waddr,
  input  logic [width-1:0]           wdata,
  input  logic                       rden,
  input  logic [rt_pkg::ray_id_w-1:0] raddr,
  output logic [width-1:0]           rdata
);

  logic [width-1:0] mem [rt_pkg::num_rays];

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, returns old contents when the write hits the same entry
  always_ff @(posedge clk) begin
    if (rden) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- logic/ray_event_decode.sv
`timescale 1ns/100ps
`default_nettype none

module ray_event_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        event_valid,
  input  logic [rt_pkg::ray_id_w-1:0] event_ray_id,
  input  logic                        event_is_shadow,
  input  logic                        event_is_miss,
  output logic                        event_stall,
  output logic                        dec_valid,
  output logic [rt_pkg::ray_id_w-1:0] dec_ray_id,
  output rt_pkg::ray_event_e          dec_kind,
  input  logic                        exec_stall
);

  rt_pkg::ray_event_e kind;

  always_comb begin
    case ({event_is_shadow, event_is_miss})
      2'b00:   kind = rt_pkg::ev_hit;
      2'b01:   kind = rt_pkg::ev_miss;
      2'b11:   kind = rt_pkg::ev_shadow_lit;
      default: kind = rt_pkg::ev_shadow_blocked;
    endcase
  end

  // Execute also stalls through its clear sweep while this stage is empty,
  // so the source is held off for the whole sweep
  assign event_stall = exec_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (!exec_stall) begin
      dec_valid <= event_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!exec_stall && event_valid) begin
      dec_ray_id <= event_ray_id;
      dec_kind   <= kind;
    end
  end

endmodule

`default_nettype wire

//--- logic/ray_state_top.sv
`timescale 1ns/100ps
`default_nettype none

module ray_state_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [rt_pkg::bounce_w-1:0] max_reflect,
  input  logic                        event_valid,
  input  logic [rt_pkg::ray_id_w-1:0] event_ray_id,
  input  logic                        event_is_shadow,
  input  logic                        event_is_miss,
  output logic                        event_stall,
  input  logic                        tri_wren,
  input  logic [rt_pkg::ray_id_w-1:0] tri_waddr,
  input  logic [rt_pkg::tri_id_w-1:0] tri_wdata,
  output logic                        scache_valid,
  output logic [rt_pkg::ray_id_w-1:0] scache_ray_id,
  output logic [rt_pkg::tri_id_w-1:0] scache_tri_id,
  output logic                        scache_is_shadow,
  output logic                        scache_is_miss,
  output logic                        scache_is_last,
  input  logic                        scache_stall
);

  logic dec_valid;
  logic [rt_pkg::ray_id_w-1:0] dec_ray_id;
  rt_pkg::ray_event_e dec_kind;
  logic exec_stall;

  logic res_valid;
  logic [rt_pkg::ray_id_w-1:0] res_ray_id;
  logic [rt_pkg::tri_id_w-1:0] res_tri_id;
  logic res_is_shadow;
  logic res_is_miss;
  logic res_is_last;
  logic res_full;

  ray_event_decode i_ray_event_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .event_valid    (event_valid),
    .event_ray_id   (event_ray_id),
    .event_is_shadow(event_is_shadow),
    .event_is_miss  (event_is_miss),
    .event_stall    (event_stall),
    .dec_valid      (dec_valid),
    .dec_ray_id     (dec_ray_id),
    .dec_kind       (dec_kind),
    .exec_stall     (exec_stall)
  );

  bounce_state_exec i_bounce_state_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .dec_ray_id   (dec_ray_id),
    .dec_kind     (dec_kind),
    .exec_stall   (exec_stall),
    .tri_wren     (tri_wren),
    .tri_waddr    (tri_waddr),
    .tri_wdata    (tri_wdata),
    .max_reflect  (max_reflect),
    .res_valid    (res_valid),
    .res_ray_id   (res_ray_id),
    .res_tri_id   (res_tri_id),
    .res_is_shadow(res_is_shadow),
    .res_is_miss  (res_is_miss),
    .res_is_last  (res_is_last),
    .res_full     (res_full)
  );

  scache_out_fifo i_scache_out_fifo (
    .clk             (clk),
    .rst_n           (rst_n),
    .res_valid       (res_valid),
    .res_ray_id      (res_ray_id),
    .res_tri_id      (res_tri_id),
    .res_is_shadow   (res_is_shadow),
    .res_is_miss     (res_is_miss),
    .res_is_last     (res_is_last),
    .res_full        (res_full),
    .scache_valid    (scache_valid),
    .scache_ray_id   (scache_ray_id),
    .scache_tri_id   (scache_tri_id),
    .scache_is_shadow(scache_is_shadow),
    .scache_is_miss  (scache_is_miss),
    .scache_is_last  (scache_is_last),
    .scache_stall    (scache_stall)
  );

endmodule

`default_nettype wire

//--- logic/rt_pkg.sv
`default_nettype none

package rt_pkg;

  // Ray and table sizing
  localparam int ray_id_w = 9;
  localparam int num_rays = 512;
  localparam logic [ray_id_w-1:0] last_ray_id = ray_id_w'(num_rays - 1);

  // Payload widths
  localparam int tri_id_w = 16;
  localparam int bounce_w = 4;

  // Result queue toward the shading cache
  localparam int out_fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(out_fifo_depth);
  localparam int fifo_cnt_w = $clog2(out_fifo_depth + 1);

  // Event kind, encoded as {is_shadow, is_miss}
  typedef enum logic [1:0] {
    ev_hit            = 2'b00,
    ev_miss           = 2'b01,
    ev_shadow_blocked = 2'b10,
    ev_shadow_lit     = 2'b11
  } ray_event_e;

  // Execute stage sequencing after reset
  typedef enum logic {
    st_clear = 1'b0,
    st_run   = 1'b1
  } exec_state_e;

endpackage

`default_nettype wire

//--- logic/scache_out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module scache_out_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        res_valid,
  input  logic [rt_pkg::ray_id_w-1:0] res_ray_id,
  input  logic [rt_pkg::tri_id_w-1:0] res_tri_id,
  input  logic                        res_is_shadow,
  input  logic                        res_is_miss,
  input  logic                        res_is_last,
  output logic                        res_full,
  output logic                        scache_valid,
  output logic [rt_pkg::ray_id_w-1:0] scache_ray_id,
  output logic [rt_pkg::tri_id_w-1:0] scache_tri_id,
  output logic                        scache_is_shadow,
  output logic                        scache_is_miss,
  output logic                        scache_is_last,
  input  logic                        scache_stall
);

  logic [rt_pkg::ray_id_w-1:0] ray_mem [rt_pkg::out_fifo_depth];
  logic [rt_pkg::tri_id_w-1:0] tri_mem [rt_pkg::out_fifo_depth];
  logic [2:0] flag_mem [rt_pkg::out_fifo_depth];

  logic [rt_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [rt_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [rt_pkg::fifo_cnt_w-1:0] count;
  logic push;
  logic pop;

  // Execute holds its write stage, and with it every in-flight record, while
  // this is high. Pops are left out so the stall never reaches upstream
  // combinationally from the shading cache
  assign res_full = (count == rt_pkg::fifo_cnt_w'(rt_pkg::out_fifo_depth));

  assign push = res_valid;
  assign pop  = scache_valid && !scache_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == rt_pkg::fifo_ptr_w'(rt_pkg::out_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == rt_pkg::fifo_ptr_w'(rt_pkg::out_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ray_mem[wr_ptr]  <= res_ray_id;
      tri_mem[wr_ptr]  <= res_tri_id;
      flag_mem[wr_ptr] <= {res_is_shadow, res_is_miss, res_is_last};
    end
  end

  // Head entry stays put until it is taken
  assign scache_valid     = (count != '0);
  assign scache_ray_id    = ray_mem[rd_ptr];
  assign scache_tri_id    = tri_mem[rd_ptr];
  assign scache_is_shadow = flag_mem[rd_ptr][2];
  assign scache_is_miss   = flag_mem[rd_ptr][1];
  assign scache_is_last   = flag_mem[rd_ptr][0];

endmodule

`default_nettype wire

//--- sources.f
logic/rt_pkg.sv
logic/dp_ram.sv
logic/ray_event_decode.sv
logic/bounce_state_exec.sv
logic/scache_out_fifo.sv
logic/ray_state_top.sv
testbench/ray_state_chk.sv
testbench/ray_state_monitor.sv
testbench/tb_ray_state.sv

//--- testbench/ray_state_chk.sv
`timescale 1ns/100ps
`default_nettype none

module ray_state_chk (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        event_stall,
  input logic                        scache_valid,
  input logic                        scache_stall,
  input logic [rt_pkg::ray_id_w-1:0] scache_ray_id,
  input logic [rt_pkg::tri_id_w-1:0] scache_tri_id,
  input logic                        scache_is_shadow,
  input logic                        scache_is_miss,
  input logic                        scache_is_last
);

  int fail_count = 0;
  logic [rt_pkg::ray_id_w:0] sweep_cnt;

  // Cycles since reset release, saturating at the sweep length
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_cnt <= '0;
    end else if (sweep_cnt < rt_pkg::num_rays) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  // A stalled record stays valid and unchanged
  stalled_record_held: assert property (@(posedge clk) disable iff (!rst_n)
    scache_valid && scache_stall |=> scache_valid &&
      $stable({scache_ray_id, scache_tri_id, scache_is_shadow, scache_is_miss, scache_is_last}))
    else begin
      fail_count++;
      $error("stalled scache record changed or was dropped");
    end

  no_record_in_reset: assert property (@(posedge clk) !rst_n |=> !scache_valid)
    else begin
      fail_count++;
      $error("scache_valid high while in reset");
    end

  // Source is held off for the whole clear sweep
  stall_during_sweep: assert property (@(posedge clk) disable iff (!rst_n)
    (sweep_cnt < rt_pkg::num_rays) |-> event_stall)
    else begin
      fail_count++;
      $error("event_stall low before the clear sweep finished");
    end

endmodule

`default_nettype wire

//--- testbench/ray_state_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module ray_state_monitor (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [rt_pkg::bounce_w-1:0] max_reflect,
  input  logic                        event_valid,
  input  logic [rt_pkg::ray_id_w-1:0] event_ray_id,
  input  logic                        event_is_shadow,
  input  logic                        event_is_miss,
  input  logic                        event_stall,
  input  logic                        tri_wren,
  input  logic [rt_pkg::ray_id_w-1:0] tri_waddr,
  input  logic [rt_pkg::tri_id_w-1:0] tri_wdata,
  input  logic                        scache_valid,
  input  logic [rt_pkg::ray_id_w-1:0] scache_ray_id,
  input  logic [rt_pkg::tri_id_w-1:0] scache_tri_id,
  input  logic                        scache_is_shadow,
  input  logic                        scache_is_miss,
  input  logic                        scache_is_last,
  input  logic                        scache_stall,
  output int                          mismatch_count,
  output int                          unexpected_count,
  output int                          pending
);

  typedef struct packed {
    logic [rt_pkg::ray_id_w-1:0] ray;
    logic [rt_pkg::tri_id_w-1:0] tri_id;
    logic                        shadow;
    logic                        miss;
    logic                        last;
  } record_t;

  logic [rt_pkg::tri_id_w-1:0] tri_model [rt_pkg::num_rays];
  logic [rt_pkg::bounce_w-1:0] cnt_model [rt_pkg::num_rays];
  record_t expected_q [$];

  // Counters start from zero, as after the clear sweep
  initial begin
    mismatch_count   = 0;
    unexpected_count = 0;
    pending          = 0;
    for (int i = 0; i < rt_pkg::num_rays; i++) begin
      tri_model[i] = '0;
      cnt_model[i] = '0;
    end
  end

  task automatic check_field(input string name, input logic [rt_pkg::ray_id_w-1:0] ray,
                             input logic [rt_pkg::tri_id_w-1:0] got,
                             input logic [rt_pkg::tri_id_w-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH t=%0t ray %0d %s: got 0x%0h expected 0x%0h",
               $time, ray, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    record_t exp_rec;
    record_t new_rec;
    logic [rt_pkg::bounce_w-1:0] cnt;
    if (rst_n) begin
      // Consumed records must come back in acceptance order
      if (scache_valid && !scache_stall) begin
        if (expected_q.size() == 0) begin
          unexpected_count++;
          $display("Record for ray %0d at %0t arrived with no accepted event outstanding",
                   scache_ray_id, $time);
        end else begin
          exp_rec = expected_q.pop_front();
          check_field("ray_id", exp_rec.ray, 16'(scache_ray_id), 16'(exp_rec.ray));
          check_field("tri_id", exp_rec.ray, scache_tri_id, exp_rec.tri_id);
          check_field("is_shadow", exp_rec.ray, 16'(scache_is_shadow), 16'(exp_rec.shadow));
          check_field("is_miss", exp_rec.ray, 16'(scache_is_miss), 16'(exp_rec.miss));
          check_field("is_last", exp_rec.ray, 16'(scache_is_last), 16'(exp_rec.last));
        end
      end
      if (tri_wren) begin
        tri_model[tri_waddr] = tri_wdata;
      end
      // Event log entry, applied with the bounce rules
      if (event_valid && !event_stall) begin
        cnt            = cnt_model[event_ray_id];
        new_rec.ray    = event_ray_id;
        new_rec.tri_id = tri_model[event_ray_id];
        new_rec.shadow = event_is_shadow;
        new_rec.miss   = event_is_miss;
        new_rec.last   = (!event_is_shadow && event_is_miss) ||
                         (event_is_shadow && cnt == max_reflect);
        cnt_model[event_ray_id] = new_rec.last ? '0 : cnt + 1'b1;
        expected_q.push_back(new_rec);
      end
      pending = expected_q.size();
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_ray_state.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ray_state;

  localparam int phase2_events = 2000;
  localparam int phase4_events = 500;
  localparam int reload_writes = 32;
  localparam int pool_size     = 8;
  localparam int num_writes    = rt_pkg::num_rays + reload_writes;
  localparam int timeout_cycles =
    2 * (phase2_events + phase4_events + num_writes) + rt_pkg::num_rays;

  logic clk;
  logic rst_n;
  logic [rt_pkg::bounce_w-1:0] max_reflect;
  logic event_valid;
  logic [rt_pkg::ray_id_w-1:0] event_ray_id;
  logic event_is_shadow;
  logic event_is_miss;
  logic event_stall;
  logic tri_wren;
  logic [rt_pkg::ray_id_w-1:0] tri_waddr;
  logic [rt_pkg::tri_id_w-1:0] tri_wdata;
  logic scache_valid;
  logic [rt_pkg::ray_id_w-1:0] scache_ray_id;
  logic [rt_pkg::tri_id_w-1:0] scache_tri_id;
  logic scache_is_shadow;
  logic scache_is_miss;
  logic scache_is_last;
  logic scache_stall;

  int mismatch_count;
  int unexpected_count;
  int pending;
  int other_errors = 0;
  int cycle_count = 0;
  logic [31:0] lcg_state = 32'd15827;
  logic [rt_pkg::ray_id_w-1:0] pool [pool_size];
  logic [rt_pkg::ray_id_w-1:0] reload_addr [reload_writes];

  ray_state_top i_ray_state_top (
    .clk(clk), .rst_n(rst_n), .max_reflect(max_reflect),
    .event_valid(event_valid), .event_ray_id(event_ray_id),
    .event_is_shadow(event_is_shadow), .event_is_miss(event_is_miss),
    .event_stall(event_stall),
    .tri_wren(tri_wren), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
    .scache_valid(scache_valid), .scache_ray_id(scache_ray_id),
    .scache_tri_id(scache_tri_id), .scache_is_shadow(scache_is_shadow),
    .scache_is_miss(scache_is_miss), .scache_is_last(scache_is_last),
    .scache_stall(scache_stall)
  );

  ray_state_monitor i_ray_state_monitor (
    .clk(clk), .rst_n(rst_n), .max_reflect(max_reflect),
    .event_valid(event_valid), .event_ray_id(event_ray_id),
    .event_is_shadow(event_is_shadow), .event_is_miss(event_is_miss),
    .event_stall(event_stall),
    .tri_wren(tri_wren), .tri_waddr(tri_waddr), .tri_wdata(tri_wdata),
    .scache_valid(scache_valid), .scache_ray_id(scache_ray_id),
    .scache_tri_id(scache_tri_id), .scache_is_shadow(scache_is_shadow),
    .scache_is_miss(scache_is_miss), .scache_is_last(scache_is_last),
    .scache_stall(scache_stall),
    .mismatch_count(mismatch_count), .unexpected_count(unexpected_count),
    .pending(pending)
  );

  bind ray_state_top ray_state_chk i_ray_state_chk (
    .clk(clk), .rst_n(rst_n), .event_stall(event_stall),
    .scache_valid(scache_valid), .scache_stall(scache_stall),
    .scache_ray_id(scache_ray_id), .scache_tri_id(scache_tri_id),
    .scache_is_shadow(scache_is_shadow), .scache_is_miss(scache_is_miss),
    .scache_is_last(scache_is_last)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic int total_errors();
    return mismatch_count + unexpected_count + other_errors +
           i_ray_state_top.i_ray_state_chk.fail_count;
  endfunction

  task automatic report_counts();
    $display("Errors: mismatch %0d, unexpected %0d, assertion %0d, other %0d",
             mismatch_count, unexpected_count,
             i_ray_state_top.i_ray_state_chk.fail_count, other_errors);
  endtask

  task automatic write_triangle(input logic [rt_pkg::ray_id_w-1:0] addr);
    @(negedge clk);
    tri_wren  = 1'b1;
    tri_waddr = addr;
    tri_wdata = lcg_next();
  endtask

  // Random events from the pool, held while stalled, until enough are accepted
  task automatic run_events(input int count);
    int accepted;
    logic held;
    logic [15:0] r;
    accepted = 0;
    held     = 1'b0;
    while (accepted < count) begin
      @(negedge clk);
      r = lcg_next();
      scache_stall = (r[1:0] == 2'b00);
      if (!held) begin
        r = lcg_next();
        event_valid     = (r[1:0] != 2'b00);
        event_ray_id    = pool[r[15:8] % pool_size];
        event_is_shadow = r[2];
        event_is_miss   = r[3];
      end
      @(posedge clk);
      held = event_valid && event_stall;
      if (event_valid && !event_stall) begin
        accepted++;
      end
    end
  endtask

  // Idle the source and let every outstanding record leave
  task automatic drain();
    @(negedge clk);
    event_valid  = 1'b0;
    scache_stall = 1'b0;
    while (pending != 0) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      other_errors++;
      report_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    logic [15:0] r;
    clk             = 1'b0;
    rst_n           = 1'b0;
    max_reflect     = 4'd3;
    event_valid     = 1'b0;
    event_ray_id    = '0;
    event_is_shadow = 1'b0;
    event_is_miss   = 1'b0;
    tri_wren        = 1'b0;
    tri_waddr       = '0;
    tri_wdata       = '0;
    scache_stall    = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Phase 1, full triangle table while the sweep runs
    for (int i = 0; i < rt_pkg::num_rays; i++) begin
      write_triangle(rt_pkg::ray_id_w'(i));
    end
    @(negedge clk);
    tri_wren = 1'b0;
    while (event_stall) begin
      @(negedge clk);
    end

    // Phase 2
    for (int i = 0; i < pool_size; i++) begin
      r       = lcg_next();
      pool[i] = r[rt_pkg::ray_id_w-1:0];
    end
    run_events(phase2_events);
    drain();

    // Phase 3, reload part of the table
    for (int i = 0; i < reload_writes; i++) begin
      r              = lcg_next();
      reload_addr[i] = r[rt_pkg::ray_id_w-1:0];
      write_triangle(reload_addr[i]);
    end
    @(negedge clk);
    tri_wren    = 1'b0;
    max_reflect = 4'd1;

    // Phase 4 uses rays whose triangle was just rewritten
    for (int i = 0; i < pool_size; i++) begin
      r       = lcg_next();
      pool[i] = reload_addr[r % reload_writes];
    end
    run_events(phase4_events);
    drain();
    repeat (4) @(negedge clk);

    report_counts();
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
